// File: src/hexdump_defines.svh
// hex dump overlay sizing
// grid, window and decoder pipeline constants shared by all blocks
`ifndef HEXDUMP_DEFINES_SVH
`define HEXDUMP_DEFINES_SVH

// window is 128 x 16 pixels
`define HEX_X_BITS 7
`define HEX_Y_BITS 4

// 128-bit word, 32 digits
`define HEX_DATA_BITS 128
`define HEX_ROW_BITS 4    // 16 digits per text row

// 8x8 cell, glyph uses the left 5 columns
`define HEX_CELL_BITS 3
`define HEX_GLYPH_COLS 5

// cycles from scanValid to pixelValid
`define HEX_PIPE_DEPTH 4

`endif

// File: src/hexPkg.sv
// hex dump overlay types
// coordinate and pixel vector types, scanner states and the digit palette
`include "hexdump_defines.svh"

package hexPkg;

  typedef logic [`HEX_X_BITS-1:0] xCoordT;
  typedef logic [`HEX_Y_BITS-1:0] yCoordT;
  typedef logic [3:0] nibbleT;
  typedef logic [`HEX_GLYPH_COLS-1:0] glyphRowT; // bit n is column n
  typedef logic [15:0] colorT; // RGB565
  typedef logic [`HEX_DATA_BITS-1:0] hexWordT;

  typedef enum logic {scanIdle, scanRun} scanStateT;

  localparam colorT COLOR_WHITE = 16'hFFFF;

  // background color per digit value
  function automatic colorT paletteColor(input nibbleT digit);
    case (digit)
      4'h0: paletteColor = 16'h0000; // black
      4'h1: paletteColor = 16'h4000; // dark red
      4'h2: paletteColor = 16'h2100; // dark brown
      4'h3: paletteColor = 16'h4200; // dark yellow
      4'h4: paletteColor = 16'h0200; // dark green
      4'h5: paletteColor = 16'h0208; // dark cyan
      4'h6: paletteColor = 16'h0008; // dark blue
      4'h7: paletteColor = 16'h4008; // dark violet
      4'h8: paletteColor = 16'h630C; // gray
      4'h9: paletteColor = 16'h8000; // light red
      4'hA: paletteColor = 16'h4200; // orange, same code as dark yellow
      4'hB: paletteColor = 16'h8400; // light yellow
      4'hC: paletteColor = 16'h0400; // light green
      4'hD: paletteColor = 16'h0410; // light cyan
      4'hE: paletteColor = 16'h0010; // light blue
      default: paletteColor = 16'h8010; // light violet
    endcase
  endfunction

endpackage

// File: src/scanGen.sv
// raster scanner for the hex window
// issues one x-major coordinate per enabled cycle, flags (0,0) as frame start
module scanGen (
  input  logic           clk,
  input  logic           rstN,
  input  logic           pixelEn,
  output hexPkg::xCoordT x,
  output hexPkg::yCoordT y,
  output logic           scanValid,
  output logic           frameStart
);

  hexPkg::scanStateT state;

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      state      <= hexPkg::scanIdle;
      x          <= '0;
      y          <= '0;
      scanValid  <= 1'b0;
      frameStart <= 1'b0;
    end
    else
    begin
      scanValid  <= pixelEn; // stall issues nothing
      frameStart <= 1'b0;
      if (pixelEn)
      begin
        if (state == hexPkg::scanIdle)
        begin
          // first pixel is (0,0), counters already cleared
          state      <= hexPkg::scanRun;
          frameStart <= 1'b1;
        end
        else
        begin
          x <= x + 1'b1; // wraps at 127
          if (&x)
            y <= y + 1'b1; // wraps after 15
          frameStart <= &x && &y; // next one is (0,0)
        end
      end
    end
  end

endmodule

// File: src/hexSnapshot.sv
// displayed word double buffer
// loads wait in a pending register and move to the display at frame start
module hexSnapshot (
  input  logic            clk,
  input  logic            rstN,
  input  logic            load,
  input  hexPkg::hexWordT dataIn,
  input  logic            frameStart,
  output hexPkg::hexWordT shown
);

  hexPkg::hexWordT pending;
  logic            pendingFlag;

  always_ff @(posedge clk)
    if (load)
      pending <= dataIn;

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      pendingFlag <= 1'b0;
      shown       <= '0;
    end
    else
    begin
      if (frameStart && pendingFlag)
      begin
        shown       <= pending; // old pending, a same-cycle load waits
        pendingFlag <= 1'b0;
      end
      if (load)
        pendingFlag <= 1'b1;
    end
  end

endmodule

// File: src/fontRom.sv
// 5x8 hex glyph table
// one glyph row per digit and row, row 7 always blank
`include "hexdump_defines.svh"

module fontRom (
  input  hexPkg::nibbleT   digit,
  input  logic [2:0]       row,
  output hexPkg::glyphRowT bits
);

  logic [0:6][4:0]  glyph;   // drawn rows, leftmost pixel in the msb
  hexPkg::glyphRowT rowBits;

  always_comb
  begin
    case (digit)
      4'h0: glyph = {5'b01110, 5'b10001, 5'b10011, 5'b10101, 5'b11001, 5'b10001, 5'b01110};
      4'h1: glyph = {5'b00100, 5'b01100, 5'b00100, 5'b00100, 5'b00100, 5'b00100, 5'b01110};
      4'h2: glyph = {5'b01110, 5'b10001, 5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b11111};
      4'h3: glyph = {5'b11111, 5'b00010, 5'b00100, 5'b00010, 5'b00001, 5'b10001, 5'b01110};
      4'h4: glyph = {5'b00010, 5'b00110, 5'b01010, 5'b10010, 5'b11111, 5'b00010, 5'b00010};
      4'h5: glyph = {5'b11111, 5'b10000, 5'b11110, 5'b00001, 5'b00001, 5'b10001, 5'b01110};
      4'h6: glyph = {5'b00110, 5'b01000, 5'b10000, 5'b11110, 5'b10001, 5'b10001, 5'b01110};
      4'h7: glyph = {5'b11111, 5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b01000, 5'b01000};
      4'h8: glyph = {5'b01110, 5'b10001, 5'b10001, 5'b01110, 5'b10001, 5'b10001, 5'b01110};
      4'h9: glyph = {5'b01110, 5'b10001, 5'b10001, 5'b01111, 5'b00001, 5'b00010, 5'b01100};
      4'hA: glyph = {5'b01110, 5'b10001, 5'b10001, 5'b11111, 5'b10001, 5'b10001, 5'b10001};
      4'hB: glyph = {5'b11110, 5'b10001, 5'b10001, 5'b11110, 5'b10001, 5'b10001, 5'b11110};
      4'hC: glyph = {5'b01110, 5'b10001, 5'b10000, 5'b10000, 5'b10000, 5'b10001, 5'b01110};
      4'hD: glyph = {5'b11100, 5'b10010, 5'b10001, 5'b10001, 5'b10001, 5'b10010, 5'b11100};
      4'hE: glyph = {5'b11111, 5'b10000, 5'b10000, 5'b11110, 5'b10000, 5'b10000, 5'b11111};
      default: glyph = {5'b11111, 5'b10000, 5'b10000, 5'b11110, 5'b10000, 5'b10000, 5'b10000};
    endcase
    rowBits = (row == 3'd7) ? '0 : glyph[row]; // spacing row
    for (int i = 0; i < `HEX_GLYPH_COLS; i++)
      bits[i] = rowBits[`HEX_GLYPH_COLS-1-i]; // bit 0 is the left column
  end

endmodule

// File: src/hexDecoder.sv
// pipelined hex digit decoder
// four stages from window coordinate to RGB565 pixel on an 8x8 cell grid,
// with the coordinate, valid and frame flag delayed to match
`include "hexdump_defines.svh"

module hexDecoder (
  input  logic            clk,
  input  logic            rstN,
  input  hexPkg::xCoordT  x,
  input  hexPkg::yCoordT  y,
  input  logic            scanValid,
  input  hexPkg::hexWordT shown,
  output hexPkg::colorT   color,
  output hexPkg::xCoordT  pixelX,
  output hexPkg::yCoordT  pixelY,
  output logic            pixelValid,
  output logic            frameOut
);

  localparam int Depth = `HEX_PIPE_DEPTH;

  logic [`HEX_ROW_BITS-1:0]  xDiv1;
  logic [`HEX_CELL_BITS-1:0] xMod1, xMod2;
  hexPkg::yCoordT            y1;
  logic [`HEX_Y_BITS-`HEX_CELL_BITS+`HEX_ROW_BITS-1:0] digitIdx;
  hexPkg::nibbleT            digit2;
  logic [`HEX_CELL_BITS-1:0] yRow2;
  hexPkg::glyphRowT          fontBits;
  hexPkg::colorT             background3;
  logic                      pixelOn3;
  hexPkg::colorT             color4;

  logic [Depth-1:0]          validPipe;
  logic [Depth-1:0]          framePipe;
  hexPkg::xCoordT            xPipe [Depth];
  hexPkg::yCoordT            yPipe [Depth];

  assign digitIdx = {y1[`HEX_Y_BITS-1:`HEX_CELL_BITS], xDiv1}; // y/8*16 + x/8

  fontRom uFont (
    .digit (digit2),
    .row   (yRow2),
    .bits  (fontBits)
  );

  always_ff @(posedge clk)
  begin
    // stage 1 cell column and column in cell
    xDiv1 <= x[`HEX_CELL_BITS+`HEX_ROW_BITS-1:`HEX_CELL_BITS];
    xMod1 <= x[`HEX_CELL_BITS-1:0];
    y1    <= y;
    // stage 2 digit select
    digit2 <= shown[4*digitIdx +: 4];
    xMod2  <= xMod1;
    yRow2  <= y1[`HEX_CELL_BITS-1:0];
    // stage 3 palette and font bit
    background3 <= hexPkg::paletteColor(digit2);
    pixelOn3    <= (xMod2 < `HEX_GLYPH_COLS) ? fontBits[xMod2] : 1'b0;
    // stage 4
    color4 <= pixelOn3 ? hexPkg::COLOR_WHITE : background3;
  end

  // coordinate labels follow the color
  always_ff @(posedge clk)
  begin
    xPipe[0] <= x;
    yPipe[0] <= y;
    for (int i = 1; i < Depth; i++)
    begin
      xPipe[i] <= xPipe[i-1];
      yPipe[i] <= yPipe[i-1];
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      validPipe <= '0;
      framePipe <= '0;
    end
    else
    begin
      validPipe <= {validPipe[Depth-2:0], scanValid};
      framePipe <= {framePipe[Depth-2:0], scanValid && x == '0 && y == '0}; // pixel (0,0)
    end
  end

  assign color      = color4;
  assign pixelX     = xPipe[Depth-1];
  assign pixelY     = yPipe[Depth-1];
  assign pixelValid = validPipe[Depth-1];
  assign frameOut   = framePipe[Depth-1];

endmodule

// File: src/hexDisplayTop.sv
// hex dump overlay top level
// scanner feeds the decoder, the snapshot holds the word shown in each frame
module hexDisplayTop (
  input  logic            clk,
  input  logic            rstN,
  input  logic            load,
  input  hexPkg::hexWordT dataIn,
  input  logic            pixelEn,
  output hexPkg::colorT   color,
  output hexPkg::xCoordT  pixelX,
  output hexPkg::yCoordT  pixelY,
  output logic            pixelValid,
  output logic            frameStart
);

  hexPkg::xCoordT  scanX;
  hexPkg::yCoordT  scanY;
  logic            scanValid;
  logic            scanFrame; // goes with scanner pixel (0,0)
  hexPkg::hexWordT shown;

  scanGen uScan (
    .clk        (clk),
    .rstN       (rstN),
    .pixelEn    (pixelEn),
    .x          (scanX),
    .y          (scanY),
    .scanValid  (scanValid),
    .frameStart (scanFrame)
  );

  hexSnapshot uSnap (
    .clk        (clk),
    .rstN       (rstN),
    .load       (load),
    .dataIn     (dataIn),
    .frameStart (scanFrame),
    .shown      (shown)
  );

  hexDecoder uDec (
    .clk        (clk),
    .rstN       (rstN),
    .x          (scanX),
    .y          (scanY),
    .scanValid  (scanValid),
    .shown      (shown),
    .color      (color),
    .pixelX     (pixelX),
    .pixelY     (pixelY),
    .pixelValid (pixelValid),
    .frameOut   (frameStart) // scanner frame start, 4 cycles later
  );

endmodule

// File: tb/hexChecker.sv
// output checker for the hex display
// follows valid latency, raster order and frame marks of the DUT output
// and compares probed pixels with their expected colors
`include "hexdump_defines.svh"

module hexChecker (
  input  logic           clk,
  input  logic           rstN,
  input  logic           pixelEn,
  input  hexPkg::colorT  color,
  input  hexPkg::xCoordT pixelX,
  input  hexPkg::yCoordT pixelY,
  input  logic           pixelValid,
  input  logic           frameStart,
  input  logic           probeAdd,
  input  logic           probeArm,
  input  hexPkg::xCoordT probeX,
  input  hexPkg::yCoordT probeY,
  input  hexPkg::colorT  probeColor,
  output int             errorCount,
  output int             probeCount,
  output int             batchesStarted,
  output int             batchesDone
);

  localparam int Lag = `HEX_PIPE_DEPTH + 1; // scanner register plus decoder

  int             batchArmed;
  int             current;  // batch of the frame on screen, -1 for none
  hexPkg::xCoordT nextX;
  hexPkg::yCoordT nextY;
  logic [Lag-1:0] enHist;   // pixelEn as sampled, newest in bit 0
  hexPkg::xCoordT pX [$];
  hexPkg::yCoordT pY [$];
  hexPkg::colorT  pColor [$];
  int             pBatch [$];
  bit             pSeen [$];

  task automatic logMismatch(input string msg);
    $display("ERR %0t: %s", $time, msg);
    errorCount++;
  endtask

  always @(posedge clk)
  begin
    if (!rstN)
    begin
      errorCount     = 0;
      probeCount     = 0;
      batchesStarted = 0;
      batchesDone    = 0;
      batchArmed     = 0;
      current        = -1;
      nextX          = '0;
      nextY          = '0;
      enHist         = '0;
    end
    else
    begin
      if (pixelValid !== enHist[Lag-1])
        logMismatch($sformatf("pixelValid %b, expected %b", pixelValid, enHist[Lag-1]));
      enHist = {enHist[Lag-2:0], pixelEn};
      if (frameStart !== (pixelValid && pixelX == '0 && pixelY == '0))
        logMismatch($sformatf("frameStart %b at (%0d,%0d) valid %b",
                              frameStart, pixelX, pixelY, pixelValid));
      if (pixelValid)
      begin
        if (pixelX !== nextX || pixelY !== nextY)
          logMismatch($sformatf("pixel (%0d,%0d), expected (%0d,%0d)",
                                pixelX, pixelY, nextX, nextY));
        nextX = pixelX + 1'b1;
        nextY = (&pixelX) ? pixelY + 1'b1 : pixelY;
        if (frameStart)
        begin
          // close the old batch, open the next armed one
          for (int i = 0; i < pX.size(); i++)
          begin
            if (current >= 0 && pBatch[i] == current && !pSeen[i])
            begin
              $display("Probe at (%0d,%0d) never appeared in its frame", pX[i], pY[i]);
              errorCount++;
            end
          end
          if (current >= 0)
            batchesDone++;
          current = -1;
          if (batchesStarted < batchArmed)
          begin
            current = batchesStarted;
            batchesStarted++;
          end
        end
        for (int i = 0; i < pX.size(); i++)
        begin
          if (pBatch[i] == current && pX[i] == pixelX && pY[i] == pixelY)
          begin
            pSeen[i] = 1'b1;
            probeCount++;
            if (color !== pColor[i])
              logMismatch($sformatf("pixel (%0d,%0d) color %h, expected %h",
                                    pixelX, pixelY, color, pColor[i]));
          end
        end
      end
      if (probeAdd)
      begin
        pX.push_back(probeX);
        pY.push_back(probeY);
        pColor.push_back(probeColor);
        pBatch.push_back(batchArmed);
        pSeen.push_back(1'b0);
      end
      if (probeArm)
        batchArmed++;
    end
  end

endmodule

// File: tb/tbHexDisplay.sv
// hex dump overlay testbench
// loads words from the pattern file, drops pixelEn at random and hands
// the probes of each word to the checker
`include "hexdump_defines.svh"

module tbHexDisplay;

  localparam int FramePixels = 1 << (`HEX_X_BITS + `HEX_Y_BITS);

  logic            clk;
  logic            rstN;
  logic            load;
  hexPkg::hexWordT dataIn;
  logic            pixelEn;
  hexPkg::colorT   color;
  hexPkg::xCoordT  pixelX;
  hexPkg::yCoordT  pixelY;
  logic            pixelValid;
  logic            frameStart;
  logic            probeAdd;
  logic            probeArm;
  hexPkg::xCoordT  probeX;
  hexPkg::yCoordT  probeY;
  hexPkg::colorT   probeColor;
  int              errorCount;
  int              probeCount;
  int              batchesStarted;
  int              batchesDone;
  logic            stallOn;
  int              cycleLimit = 0;
  int              cycles;

  hexPkg::hexWordT words [$];
  bit              wordMid [$];  // loaded mid-frame of the previous word
  int              probeWord [$];
  int              probeXs [$];
  int              probeYs [$];
  int              probeColors [$];

  hexDisplayTop dut (
    .clk        (clk),
    .rstN       (rstN),
    .load       (load),
    .dataIn     (dataIn),
    .pixelEn    (pixelEn),
    .color      (color),
    .pixelX     (pixelX),
    .pixelY     (pixelY),
    .pixelValid (pixelValid),
    .frameStart (frameStart)
  );

  hexChecker chk (
    .clk            (clk),
    .rstN           (rstN),
    .pixelEn        (pixelEn),
    .color          (color),
    .pixelX         (pixelX),
    .pixelY         (pixelY),
    .pixelValid     (pixelValid),
    .frameStart     (frameStart),
    .probeAdd       (probeAdd),
    .probeArm       (probeArm),
    .probeX         (probeX),
    .probeY         (probeY),
    .probeColor     (probeColor),
    .errorCount     (errorCount),
    .probeCount     (probeCount),
    .batchesStarted (batchesStarted),
    .batchesDone    (batchesDone)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // pixelEn low on about one cycle in four once running
  initial
  begin
    pixelEn = 1'b0;
    void'($urandom(1892));
    forever
    begin
      @(negedge clk);
      pixelEn = stallOn && ($urandom % 4 != 0);
    end
  end

  task automatic readPatterns();
    int              fd;
    string           line;
    hexPkg::hexWordT word;
    int              mid;
    int              px;
    int              py;
    int              pc;
    fd = $fopen("tb/hex_patterns.txt", "r");
    if (fd == 0)
      $display("Could not open the pattern file tb/hex_patterns.txt");
    else
    begin
      while ($fgets(line, fd))
      begin
        if (line.getc(0) == "w" && $sscanf(line, "w %h %d", word, mid) == 2)
        begin
          words.push_back(word);
          wordMid.push_back(mid != 0);
        end
        else if (line.getc(0) == "p" && $sscanf(line, "p %d %d %h", px, py, pc) == 3)
        begin
          probeWord.push_back(words.size() - 1);
          probeXs.push_back(px);
          probeYs.push_back(py);
          probeColors.push_back(pc);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic loadWord(input hexPkg::hexWordT word);
    @(negedge clk);
    load   = 1'b1;
    dataIn = word;
    @(negedge clk);
    load   = 1'b0;
  endtask

  task automatic waitFrame();
    @(negedge clk);
    while (!frameStart)
      @(negedge clk);
  endtask

  // probes of one word become one checker batch
  task automatic armProbes(input int w);
    for (int i = 0; i < probeWord.size(); i++)
    begin
      if (probeWord[i] == w)
      begin
        @(negedge clk);
        probeAdd   = 1'b1;
        probeX     = hexPkg::xCoordT'(probeXs[i]);
        probeY     = hexPkg::yCoordT'(probeYs[i]);
        probeColor = hexPkg::colorT'(probeColors[i]);
      end
    end
    @(negedge clk);
    probeAdd = 1'b0;
    probeArm = 1'b1;
    @(negedge clk);
    probeArm = 1'b0;
  endtask

  initial
  begin
    rstN       = 1'b0;
    load       = 1'b0;
    dataIn     = '0;
    probeAdd   = 1'b0;
    probeArm   = 1'b0;
    probeX     = '0;
    probeY     = '0;
    probeColor = '0;
    stallOn    = 1'b0;
    readPatterns();
    cycleLimit = words.size() * 3 * FramePixels * 2;
    repeat (5) @(negedge clk);
    rstN = 1'b1;
    repeat (20) @(negedge clk); // scanner idle, nothing may come out
    @(posedge clk);
    stallOn = 1'b1;
    for (int w = 0; w < words.size(); w++)
    begin
      if (!wordMid[w])
      begin
        loadWord(words[w]);
        waitFrame(); // may still show the old word
        armProbes(w);
      end
      if (w + 1 < words.size() && wordMid[w+1])
      begin
        while (batchesStarted <= w)
          @(negedge clk);
        while (!(pixelValid && pixelY == 8))
          @(negedge clk);
        loadWord(words[w+1]); // halfway down the frame of word w
        armProbes(w + 1);
      end
      while (batchesDone <= w)
        @(negedge clk);
    end
    $display("Probes compared: %0d of %0d, errors: %0d",
             probeCount, probeXs.size(), errorCount);
    if (errorCount == 0 && probeXs.size() > 0 && probeCount == probeXs.size())
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  // words times 3 frames, doubled for stalls
  initial
  begin
    cycles = 0;
    wait (cycleLimit > 0);
    while (cycles < cycleLimit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: tb/hex_patterns.txt
# w <word as 32 hex digits, digit 0 rightmost> <1 = load mid-frame of the previous word>
# p <x> <y> <expected RGB565 color in hex> checked in the first frame showing the word
w FEDCBA9876543210FEDCBA9876543210 0
p 6 3 0000
p 14 3 4000
p 22 3 2100
p 30 3 4200
p 38 3 0200
p 46 3 0208
p 54 3 0008
p 62 3 4008
p 70 3 630C
p 78 3 8000
p 86 3 4200
p 94 3 8400
p 102 3 0400
p 110 3 0410
p 118 3 0010
p 126 3 8010
p 1 0 FFFF
p 0 0 0000
p 66 3 FFFF
p 125 0 8010
p 80 11 FFFF
p 82 15 4200
w 0123456789ABCDEF0123456789ABCDEF 0
p 12 0 FFFF
p 9 1 0010
p 20 10 FFFF
p 126 15 0000
w 33333333333333339999999999999999 1
p 12 0 8000
p 20 10 4200
p 18 10 FFFF
p 126 15 4200
w A5A5A5A5A5A5A5A55A5A5A5A5A5A5A5A 0
p 2 3 FFFF
p 12 2 0208
p 4 8 FFFF
p 14 8 4200

// File: compile.f
+incdir+src
src/hexPkg.sv
src/scanGen.sv
src/hexSnapshot.sv
src/fontRom.sv
src/hexDecoder.sv
src/hexDisplayTop.sv
tb/hexChecker.sv
tb/tbHexDisplay.sv

// File: Makefile
# Verilator flow for the hex display testbench
TOP = tbHexDisplay

lint:
	verilator --lint-only --timing -Wall -Wno-fatal -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

.PHONY: lint sim clean
